//--- rf_pg_top.f
verilog/rf_pg_types_pkg.sv
verilog/rf_pg_ctrl_pkg.sv
verilog/pg_timer.sv
verilog/pg_sequencer.sv
verilog/rf_access_gate.sv
verilog/rf_array_64x2.sv
verilog/rf_pg_top.sv
tests/rf_pg_tb.sv

//--- tests/rf_pg_tb.sv
// Power gated register file testbench

module rf_pg_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rf_pg_types_pkg::*;

    // Power-up is bounded at 100 cycles and happens twice, and 128 row reads,
    // 200 random accesses and about 20 refused cycles add up to roughly 600
    // cycles of work, so a limit of 2000 leaves a wide margin
    localparam int POWER_UP_BOUND = 100;
    localparam int N_RANDOM       = 200;
    localparam int N_REFUSED      = 16;
    localparam int TIMEOUT_CYCLES = 2000;

    logic     clk;
    logic     rst;
    logic     pwr_req;
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
    logic     re;
    rf_addr_t raddr;
    rf_data_t rdata;
    logic     ready;
    logic     access_err;
    logic     pwr_enable_b_out;

    // Reference model of the array contents
    rf_data_t model [RF_DEPTH];

    // Expected read data and error flag, delayed by one cycle to meet the response
    rf_data_t exp_rd;
    rf_data_t exp_rd_q;
    logic     rd_chk;
    logic     err_exp;
    logic     err_exp_q;

    integer   seed;
    int       cycles = 0;
    int       err_count;
    int       test_errs;
    int       tests_passed;
    int       tests_failed;

    rf_pg_top dut0 (
         .clk(clk), .rst(rst), .pwr_req(pwr_req), .we(we), .waddr(waddr), .wdata(wdata)
        ,.re(re), .raddr(raddr), .rdata(rdata), .ready(ready), .access_err(access_err)
        ,.pwr_enable_b_out(pwr_enable_b_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        exp_rd_q  <= exp_rd;
        err_exp_q <= err_exp;
    end

    // A run that stops making progress ends here
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // --------------------
    // Checks
    // --------------------

    a_reset_flags: assert property (@(posedge clk) $fell(rst) |-> (!ready && !access_err))
        else begin
            $display("mismatch at %0t: ready/access_err after reset expected 0/0 got %b/%b",
                     $time, $sampled(ready), $sampled(access_err));
            err_count++;
        end

    a_reset_power: assert property (@(posedge clk)
        $fell(rst) |-> (rdata == '0 && pwr_enable_b_out))
        else begin
            $display("mismatch at %0t: rdata/pwr_enable_b_out after reset expected 0/1 got %h/%b",
                     $time, $sampled(rdata), $sampled(pwr_enable_b_out));
            err_count++;
        end

    // Read data arrives one cycle after the strobe
    a_read_data: assert property (@(posedge clk) disable iff (rst) rd_chk |=> (rdata == exp_rd_q))
        else begin
            $display("mismatch at %0t: rdata expected %h got %h", $time,
                     $sampled(exp_rd_q), $sampled(rdata));
            err_count++;
        end

    a_access_err: assert property (@(posedge clk) disable iff (rst) access_err == err_exp_q)
        else begin
            $display("mismatch at %0t: access_err expected %b got %b", $time,
                     $sampled(err_exp_q), $sampled(access_err));
            err_count++;
        end

    a_rdata_clamped: assert property (@(posedge clk) disable iff (rst) !ready |-> rdata == '0)
        else begin
            $display("mismatch at %0t: rdata while not ready expected 0 got %h", $time,
                     $sampled(rdata));
            err_count++;
        end

    a_power_up_bound: assert property (@(posedge clk) disable iff (rst)
        $rose(pwr_req) |-> ##[1:POWER_UP_BOUND] ready)
        else begin
            $display("ready did not rise within %0d cycles of pwr_req", POWER_UP_BOUND);
            err_count++;
        end

    a_enable_first: assert property (@(posedge clk) disable iff (rst)
        $rose(ready) |-> !$past(pwr_enable_b_out))
        else begin
            $display("ready rose while the enable acknowledge was still high");
            err_count++;
        end

    a_enable_return: assert property (@(posedge clk) disable iff (rst)
        $fell(ready) |-> ##[1:4] pwr_enable_b_out)
        else begin
            $display("pwr_enable_b_out did not return high after power-down");
            err_count++;
        end

    // --------------------
    // Stimulus helpers
    // --------------------

    task automatic drive_idle();
        we      = 1'b0;
        re      = 1'b0;
        rd_chk  = 1'b0;
        err_exp = 1'b0;
    endtask

    // An accepted access updates the model after the read has seen the old row
    task automatic drive_access(input logic w, input rf_addr_t wa, input rf_data_t wd,
                                input logic r, input rf_addr_t ra);
        we      = w;
        waddr   = wa;
        wdata   = wd;
        re      = r;
        raddr   = ra;
        rd_chk  = r;
        err_exp = 1'b0;
        exp_rd  = model[ra];
        if (w) begin
            model[wa] = wd;
        end
    endtask

    // A refused access leaves the model as it is
    task automatic drive_refused(input logic w, input logic r);
        we      = w;
        waddr   = $random(seed);
        wdata   = $random(seed);
        re      = r;
        raddr   = $random(seed);
        rd_chk  = 1'b0;
        err_exp = w || r;
    endtask

    task automatic power_up(input bit traffic);
        // Contents are lost while off and the sweep leaves every row at zero
        foreach (model[i]) begin
            model[i] = '0;
        end
        @(negedge clk);
        pwr_req = 1'b1;
        forever begin
            @(negedge clk);
            if (ready) begin
                break;
            end
            if (traffic) begin
                drive_refused($random(seed), $random(seed));
            end else begin
                drive_idle();
            end
        end
        drive_idle();
    endtask

    task automatic read_all_rows();
        for (int i = 0; i < RF_DEPTH; i++) begin
            @(negedge clk);
            drive_access(1'b0, '0, '0, 1'b1, rf_addr_t'(i));
        end
        @(negedge clk);
        drive_idle();
    endtask

    task automatic start_test();
        test_errs = err_count;
    endtask

    // Waits out the last response before judging the test
    task automatic finish_test(input string name);
        @(negedge clk);
        drive_idle();
        @(negedge clk);
        if (err_count == test_errs) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, err_count - test_errs);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        logic     w;
        logic     r;
        rf_addr_t wa;
        rf_addr_t ra;
        rf_data_t wd;

        seed         = 32'h2d11_94bf;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst          = 1'b1;
        pwr_req      = 1'b0;
        waddr        = '0;
        wdata        = '0;
        raddr        = '0;
        exp_rd       = '0;
        drive_idle();
        foreach (model[i]) begin
            model[i] = '0;
        end

        start_test();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        finish_test("reset_state");

        start_test();
        power_up(1'b0);
        read_all_rows();
        finish_test("power_up_clear");

        start_test();
        for (int k = 0; k < N_RANDOM; k++) begin
            w  = $random(seed);
            r  = $random(seed);
            wa = $random(seed);
            wd = $random(seed);
            ra = $random(seed);
            // Every fourth access aims both ports at one row
            if (k % 4 == 0) begin
                w  = 1'b1;
                r  = 1'b1;
                ra = wa;
            end
            @(negedge clk);
            drive_access(w, wa, wd, r, ra);
        end
        finish_test("random_access");

        start_test();
        @(negedge clk);
        pwr_req = 1'b0;
        while (ready) begin
            @(negedge clk);
        end
        while (!pwr_enable_b_out) begin
            @(negedge clk);
        end
        finish_test("power_down");

        start_test();
        @(negedge clk);
        drive_refused(1'b1, 1'b0);
        @(negedge clk);
        drive_refused(1'b0, 1'b1);
        for (int k = 0; k < N_REFUSED; k++) begin
            @(negedge clk);
            drive_refused($random(seed), $random(seed));
        end
        finish_test("refused_access");

        start_test();
        power_up(1'b1);
        read_all_rows();
        finish_test("power_up_again");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/rf_pg_top.sv
// Power gated register file

module rf_pg_top (
     input  logic                      clk
    ,input  logic                      rst
    ,input  logic                      pwr_req
    ,input  logic                      we
    ,input  rf_pg_types_pkg::rf_addr_t waddr
    ,input  rf_pg_types_pkg::rf_data_t wdata
    ,input  logic                      re
    ,input  rf_pg_types_pkg::rf_addr_t raddr
    ,output rf_pg_types_pkg::rf_data_t rdata
    ,output logic                      ready
    ,output logic                      access_err
    ,output logic                      pwr_enable_b_out
);

    import rf_pg_types_pkg::*;
    import rf_pg_ctrl_pkg::*;

    // Power control between sequencer and array
    logic      pwr_enable_b;
    logic      isol_en;
    logic      clear_en;

    // Timer handshake
    logic      timer_load;
    pg_count_t timer_load_val;
    pg_count_t timer_count;
    logic      timer_done;

    // Gated array port
    logic      arr_we;
    rf_addr_t  arr_waddr;
    rf_data_t  arr_wdata;
    logic      arr_re;
    rf_addr_t  arr_raddr;

    // --------------------
    // Power control
    // --------------------

    pg_sequencer u_seq (
         .clk(clk), .rst(rst), .pwr_req(pwr_req), .pwr_enable_b_out(pwr_enable_b_out)
        ,.timer_done(timer_done), .pwr_enable_b(pwr_enable_b), .isol_en(isol_en)
        ,.timer_load(timer_load), .timer_load_val(timer_load_val)
        ,.clear_en(clear_en), .ready(ready)
    );

    pg_timer u_timer (
         .clk(clk), .rst(rst), .load(timer_load), .load_val(timer_load_val)
        ,.count(timer_count), .done(timer_done)
    );

    // --------------------
    // Datapath
    // --------------------

    rf_access_gate u_gate (
         .clk(clk), .rst(rst), .we(we), .waddr(waddr), .wdata(wdata), .re(re)
        ,.raddr(raddr), .clear_en(clear_en), .ready(ready), .timer_count(timer_count)
        ,.arr_we(arr_we), .arr_waddr(arr_waddr), .arr_wdata(arr_wdata), .arr_re(arr_re)
        ,.arr_raddr(arr_raddr), .access_err(access_err)
    );

    rf_array_64x2 u_array (
         .clk(clk), .rst(rst), .we(arr_we), .waddr(arr_waddr), .wdata(arr_wdata)
        ,.re(arr_re), .raddr(arr_raddr), .pwr_enable_b(pwr_enable_b), .isol_en(isol_en)
        ,.rdata(rdata), .pwr_enable_b_out(pwr_enable_b_out)
    );

endmodule

//--- verilog/rf_array_64x2.sv
// Power gated 64x2 storage array

module rf_array_64x2 (
     input  logic                      clk
    ,input  logic                      rst
    ,input  logic                      we
    ,input  rf_pg_types_pkg::rf_addr_t waddr
    ,input  rf_pg_types_pkg::rf_data_t wdata
    ,input  logic                      re
    ,input  rf_pg_types_pkg::rf_addr_t raddr
    ,input  logic                      pwr_enable_b
    ,input  logic                      isol_en
    ,output rf_pg_types_pkg::rf_data_t rdata
    ,output logic                      pwr_enable_b_out
);

    import rf_pg_types_pkg::*;

    rf_data_t mem [RF_DEPTH];
    rf_data_t rdata_q;
    logic     pwr_enable_b_q;

    // --------------------
    // Enable chain
    // --------------------

    // One stage of the enable chain, echoed back as the acknowledge
    always_ff @(posedge clk) begin
        if (rst) begin
            pwr_enable_b_q <= 1'b1;
        end else begin
            pwr_enable_b_q <= pwr_enable_b;
        end
    end

    assign pwr_enable_b_out = pwr_enable_b_q;

    // --------------------
    // Storage
    // --------------------

    // Rows only take writes once the supply is on
    always_ff @(posedge clk) begin
        if (we && !pwr_enable_b_q) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read sees the old row on a same-cycle write
    // The read register loses its value with the supply
    always_ff @(posedge clk) begin
        if (rst || pwr_enable_b_q) begin
            rdata_q <= '0;
        end else if (re) begin
            rdata_q <= mem[raddr];
        end
    end

    // Isolation clamps the output low
    assign rdata = isol_en ? '0 : rdata_q;

    a_no_access_isolated: assert property (@(posedge clk) disable iff (rst)
        isol_en |-> !(we || re));

endmodule

//--- verilog/rf_access_gate.sv
// Array access arbitration

module rf_access_gate (
     input  logic                      clk
    ,input  logic                      rst
    ,input  logic                      we
    ,input  rf_pg_types_pkg::rf_addr_t waddr
    ,input  rf_pg_types_pkg::rf_data_t wdata
    ,input  logic                      re
    ,input  rf_pg_types_pkg::rf_addr_t raddr
    ,input  logic                      clear_en
    ,input  logic                      ready
    ,input  rf_pg_ctrl_pkg::pg_count_t timer_count
    ,output logic                      arr_we
    ,output rf_pg_types_pkg::rf_addr_t arr_waddr
    ,output rf_pg_types_pkg::rf_data_t arr_wdata
    ,output logic                      arr_re
    ,output rf_pg_types_pkg::rf_addr_t arr_raddr
    ,output logic                      access_err
);

    import rf_pg_types_pkg::*;

    // --------------------
    // Write port
    // --------------------

    // The sweep owns the write port and zeroes the row the timer points at
    assign arr_we    = clear_en || (ready && we);
    assign arr_waddr = clear_en ? rf_addr_t'(timer_count) : waddr;
    assign arr_wdata = clear_en ? '0 : wdata;

    // --------------------
    // Read port
    // --------------------

    // Address passes straight through; only the strobe is qualified
    assign arr_re    = ready && re;
    assign arr_raddr = raddr;

    // --------------------
    // Refused accesses
    // --------------------

    // Anything issued while not ready is dropped and flagged one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            access_err <= 1'b0;
        end else begin
            access_err <= !ready && (we || re);
        end
    end

    // The sequencer keeps user writes and the sweep apart
    a_single_writer: assert property (@(posedge clk) disable iff (rst)
        (clear_en && we) |-> !ready);

endmodule

//--- verilog/pg_sequencer.sv
// Power gating sequencer

module pg_sequencer (
     input  logic                      clk
    ,input  logic                      rst
    ,input  logic                      pwr_req
    ,input  logic                      pwr_enable_b_out
    ,input  logic                      timer_done
    ,output logic                      pwr_enable_b
    ,output logic                      isol_en
    ,output logic                      timer_load
    ,output rf_pg_ctrl_pkg::pg_count_t timer_load_val
    ,output logic                      clear_en
    ,output logic                      ready
);

    import rf_pg_types_pkg::*;
    import rf_pg_ctrl_pkg::*;

    pg_state_t state_q;
    pg_state_t state_d;

    // --------------------
    // Next state
    // --------------------

    // A pwr_req change during power-up waits until PG_ON is reached
    always_comb begin
        state_d = state_q;
        case (state_q)
            PG_OFF:     if (pwr_req) state_d = PG_WAKE;
            // The ack is the enable after its trip through the array
            PG_WAKE:    if (!pwr_enable_b_out) state_d = PG_SETTLE;
            PG_SETTLE:  if (timer_done) state_d = PG_CLEAR;
            // Done here means the row-0 write is on the array this cycle
            PG_CLEAR:   if (timer_done) state_d = PG_ON;
            PG_ON:      if (!pwr_req) state_d = PG_ISOLATE;
            PG_ISOLATE: state_d = PG_OFF;
            default:    state_d = PG_OFF;
        endcase
    end

    // Timer loads on the same edge as the state change, so the first
    // clear cycle already sees row 63 on timer_count
    assign timer_load = ((state_q == PG_WAKE) && !pwr_enable_b_out) ||
                        ((state_q == PG_SETTLE) && timer_done);

    assign timer_load_val = (state_q == PG_WAKE) ? pg_count_t'(SETTLE_CYCLES - 1)
                                                 : pg_count_t'(RF_DEPTH - 1);

    // --------------------
    // State and outputs
    // --------------------

    // Outputs are decoded from the next state so they change with it
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= PG_OFF;
            pwr_enable_b <= 1'b1;
            isol_en      <= 1'b1;
            clear_en     <= 1'b0;
            ready        <= 1'b0;
        end else begin
            state_q      <= state_d;
            // Enable is active low and stays on through ISOLATE
            pwr_enable_b <= (state_d == PG_OFF);
            // Isolation opens for the sweep so the array sees clean writes
            isol_en      <= (state_d == PG_OFF) || (state_d == PG_WAKE) ||
                            (state_d == PG_SETTLE) || (state_d == PG_ISOLATE);
            clear_en     <= (state_d == PG_CLEAR);
            ready        <= (state_d == PG_ON);
        end
    end

    // --------------------
    // Checks
    // --------------------

    // User traffic only flows into a powered and connected array
    a_ready_powered: assert property (@(posedge clk) disable iff (rst)
        ready |-> (!isol_en && !pwr_enable_b && !pwr_enable_b_out));

    // The sweep and user accesses never overlap
    a_clear_not_ready: assert property (@(posedge clk) disable iff (rst)
        !(clear_en && ready));

endmodule

//--- verilog/pg_timer.sv
// Settle and sweep down-counter

module pg_timer (
     input  logic                      clk
    ,input  logic                      rst
    ,input  logic                      load
    ,input  rf_pg_ctrl_pkg::pg_count_t load_val
    ,output rf_pg_ctrl_pkg::pg_count_t count
    ,output logic                      done
);

    // --------------------
    // Counter
    // --------------------

    // A load wins over the decrement
    // Once at zero the count parks there until the next load
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= load_val;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Done follows the count alone because the sequencer builds its load from it
    // A load always moves the count off zero, so the next phase never sees a stale done
    assign done = (count == '0);

    // --------------------
    // Checks
    // --------------------

    // Zero holds until reloaded; a wrap would restart the sweep at row 63
    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        ((count == '0) && !load) |=> (count == '0));

endmodule

//--- verilog/rf_pg_ctrl_pkg.sv
// Power sequencing definitions

package rf_pg_ctrl_pkg;

    // --------------------
    // Sequencer states
    // --------------------

    // Power-up walks OFF, WAKE, SETTLE, CLEAR and ON in order
    // Power-down leaves ON through ISOLATE and returns to OFF
    typedef enum logic [2:0] {
        PG_OFF     = 3'd0,
        PG_WAKE    = 3'd1,
        PG_SETTLE  = 3'd2,
        PG_CLEAR   = 3'd3,
        PG_ON      = 3'd4,
        PG_ISOLATE = 3'd5
    } pg_state_t;

    // --------------------
    // Timing
    // --------------------

    // Supply settle time once the enable chain has acknowledged
    localparam int SETTLE_CYCLES = 4;

    // The timer also indexes the clear sweep, so it covers all 64 rows
    localparam int PG_COUNT_W = 6;

    typedef logic [PG_COUNT_W-1:0] pg_count_t;

endpackage

//--- verilog/rf_pg_types_pkg.sv
// Register file geometry types

package rf_pg_types_pkg;

    // --------------------
    // Array geometry
    // --------------------

    // Number of rows in the storage array
    localparam int RF_DEPTH = 64;

    // Bits held by each row
    localparam int RF_WIDTH = 2;

    // Address width follows from the depth
    localparam int RF_ADDR_W = $clog2(RF_DEPTH);

    // --------------------
    // Datapath types
    // --------------------

    // Row index for both write and read ports
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    // One row of payload
    typedef logic [RF_WIDTH-1:0] rf_data_t;

endpackage
